//--- source/gather_pkg.sv
`default_nettype none

package gather_pkg;

    // -------------------------------------------------------------------------
    // Sizes
    // -------------------------------------------------------------------------
    localparam int NUM_CTXT   = 4;
    localparam int PTR_W      = 6;
    localparam int DESC_DEPTH = 1 << PTR_W;
    localparam int SIZE_W     = 11;
    localparam int META_W     = 8;
    localparam int RESP_DEPTH = 4;
    localparam int CTXT_W     = $clog2(NUM_CTXT);

    // -------------------------------------------------------------------------
    // Types
    // -------------------------------------------------------------------------
    typedef logic [PTR_W-1:0]  ptr_t;
    typedef logic [CTXT_W-1:0] ctxt_id_t;

    // One descriptor word as stored in memory
    typedef struct packed {
        ptr_t              nxt_ptr;
        logic              eof;
        logic [SIZE_W-1:0] size;
        logic [META_W-1:0] meta;
        logic              err;
    } desc_t;

    // Response handed back to a context, ptr is the descriptor address
    typedef struct packed {
        ptr_t              ptr;
        logic              eof;
        logic [SIZE_W-1:0] size;
        logic [META_W-1:0] meta;
        logic              err;
    } gather_resp_t;

    // Outstanding memory read
    typedef struct packed {
        ctxt_id_t ctxt_id;
        ptr_t     ptr;
    } rd_ctxt_t;

endpackage : gather_pkg

`default_nettype wire

//--- source/ctxt_fifo.sv
`default_nettype none

module ctxt_fifo #(
    parameter type DATA_T = logic,
    parameter int  DEPTH  = 4
) (
    input  wire logic  clk,
    input  wire logic  srst,
    input  wire logic  wr,
    input  wire DATA_T wr_data,
    output logic       full,
    input  wire logic  rd,
    output logic       rd_vld,
    output DATA_T      rd_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    DATA_T         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    assign full    = (count == CW'(DEPTH));
    assign rd_vld  = (count != '0);
    assign do_wr   = wr && !full;
    assign do_rd   = rd && rd_vld;

    // Head entry is visible without a register stage
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy only moves when exactly one side acts
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : ctxt_fifo

`default_nettype wire

//--- source/rr_arbiter.sv
`default_nettype none

module rr_arbiter
    import gather_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                srst,
    input  wire logic                en,
    input  wire logic [NUM_CTXT-1:0] req,
    output logic      [NUM_CTXT-1:0] grant,
    output ctxt_id_t                 sel
);

    ctxt_id_t            last_q;
    logic [NUM_CTXT-1:0] grant_c;
    ctxt_id_t            sel_c;
    logic                found;

    // Search starts just after the last winner and wraps around
    always_comb begin
        int idx;
        grant_c = '0;
        sel_c   = '0;
        found   = 1'b0;
        for (int i = 1; i <= NUM_CTXT; i++) begin
            idx = (int'(last_q) + i) % NUM_CTXT;
            if (!found && req[idx]) begin
                found        = 1'b1;
                grant_c[idx] = 1'b1;
                sel_c        = ctxt_id_t'(idx);
            end
        end
    end

    assign grant = en ? grant_c : '0;
    assign sel   = sel_c;

    // Priority pointer, context 0 wins first after reset
    always_ff @(posedge clk) begin
        if (srst) begin
            last_q <= ctxt_id_t'(NUM_CTXT - 1);
        end else if (en && found) begin
            last_q <= sel_c;
        end
    end

endmodule : rr_arbiter

`default_nettype wire

//--- source/desc_mem.sv
`default_nettype none

module desc_mem
    import gather_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  srst,

    // Load port
    input  wire logic  wr,
    input  wire ptr_t  wr_addr,
    input  wire desc_t wr_data,

    // Read port
    input  wire logic  rd_req,
    input  wire ptr_t  rd_addr,
    output logic       rd_rdy,
    output logic       rd_ack,
    output desc_t      rd_data,

    output logic       init_done
);

    desc_t mem [DESC_DEPTH];
    ptr_t  init_cnt;
    logic  rd_acc;

    // -------------------------------------------------------------------------
    // Clear sequence
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == ptr_t'(DESC_DEPTH - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // Clearing owns the array until init_done
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_cnt] <= '0;
        end else if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // -------------------------------------------------------------------------
    // Read port
    // -------------------------------------------------------------------------
    assign rd_rdy = init_done;
    assign rd_acc = rd_req && rd_rdy;

    // Old contents come back on a same-address write
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_acc;
        end
    end

endmodule : desc_mem

`default_nettype wire

//--- source/gather_core.sv
`default_nettype none

module gather_core
    import gather_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                srst,
    input  wire logic                en,

    // Chain start, per context
    input  wire logic [NUM_CTXT-1:0] start_req,
    input  wire ptr_t                start_ptr [NUM_CTXT],
    output logic      [NUM_CTXT-1:0] start_rdy,

    // Responses, per context
    output logic      [NUM_CTXT-1:0] resp_valid,
    output gather_resp_t             resp [NUM_CTXT],
    input  wire logic [NUM_CTXT-1:0] resp_ack,

    // Descriptor memory read port
    output logic                     rd_req,
    output ptr_t                     rd_addr,
    input  wire logic                rd_rdy,
    input  wire logic                rd_ack,
    input  wire desc_t               rd_data,
    input  wire logic                init_done
);

    typedef enum logic [1:0] {
        RESET,
        DISABLED,
        IDLE,
        READ
    } state_t;

    state_t              state;
    state_t              nxt_state;

    logic [NUM_CTXT-1:0] busy;
    logic [NUM_CTXT-1:0] pend;
    ptr_t                cur_ptr [NUM_CTXT];
    logic [NUM_CTXT-1:0] start_acc;
    logic [NUM_CTXT-1:0] rd_done;
    logic [NUM_CTXT-1:0] resp_full;

    logic                arb_en;
    logic [NUM_CTXT-1:0] arb_req;
    logic [NUM_CTXT-1:0] grant;
    ctxt_id_t            sel;

    rd_ctxt_t            rd_ctxt_in;
    rd_ctxt_t            rd_ctxt_out;
    logic                rd_ctxt_vld;
    gather_resp_t        resp_in;

    // -------------------------------------------------------------------------
    // Per-context chain state
    // -------------------------------------------------------------------------
    assign start_rdy = ~busy;
    assign start_acc = start_req & start_rdy;

    // Only a context with room for the answer may ask for a read
    assign arb_req = pend & ~resp_full;

    always_comb begin
        for (int i = 0; i < NUM_CTXT; i++) begin
            rd_done[i] = rd_ack && rd_ctxt_vld && (rd_ctxt_out.ctxt_id == ctxt_id_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            busy <= '0;
            pend <= '0;
        end else begin
            for (int i = 0; i < NUM_CTXT; i++) begin
                if (start_acc[i]) begin
                    busy[i] <= 1'b1;
                end else if (rd_done[i] && rd_data.eof) begin
                    busy[i] <= 1'b0;
                end
                if (start_acc[i] || (rd_done[i] && !rd_data.eof)) begin
                    pend[i] <= 1'b1;
                end else if (grant[i]) begin
                    pend[i] <= 1'b0;
                end
            end
        end
    end

    // Walk the list through next pointers
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CTXT; i++) begin
            if (start_acc[i]) begin
                cur_ptr[i] <= start_ptr[i];
            end else if (rd_done[i]) begin
                cur_ptr[i] <= rd_data.nxt_ptr;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Read FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        arb_en    = 1'b0;
        rd_req    = 1'b0;
        case (state)
            RESET: begin
                if (init_done) begin
                    nxt_state = en ? IDLE : DISABLED;
                end
            end
            DISABLED: begin
                if (en) begin
                    nxt_state = IDLE;
                end
            end
            IDLE: begin
                // Arbitrate cycle
                arb_en = en;
                if (!en) begin
                    nxt_state = DISABLED;
                end else if (|arb_req) begin
                    nxt_state = READ;
                end
            end
            READ: begin
                rd_req = 1'b1;
                if (rd_rdy) begin
                    nxt_state = IDLE;
                end
            end
            default: nxt_state = RESET;
        endcase
    end

    rr_arbiter arb_i (
        .clk   (clk),
        .srst  (srst),
        .en    (arb_en),
        .req   (arb_req),
        .grant (grant),
        .sel   (sel)
    );

    // Winner's address is held for the read cycle
    always_ff @(posedge clk) begin
        if (arb_en && (|arb_req)) begin
            rd_ctxt_in.ctxt_id <= sel;
            rd_ctxt_in.ptr     <= cur_ptr[sel];
        end
    end

    assign rd_addr = rd_ctxt_in.ptr;

    // -------------------------------------------------------------------------
    // Read tracking and response queues
    // -------------------------------------------------------------------------
    ctxt_fifo #(
        .DATA_T (rd_ctxt_t),
        .DEPTH  (NUM_CTXT)
    ) rd_ctxt_fifo_i (
        .clk     (clk),
        .srst    (srst),
        .wr      (rd_req && rd_rdy),
        .wr_data (rd_ctxt_in),
        .full    (),
        .rd      (rd_ack),
        .rd_vld  (rd_ctxt_vld),
        .rd_data (rd_ctxt_out)
    );

    always_comb begin
        resp_in.ptr  = rd_ctxt_out.ptr;
        resp_in.eof  = rd_data.eof;
        resp_in.size = rd_data.size;
        resp_in.meta = rd_data.meta;
        resp_in.err  = rd_data.err;
    end

    for (genvar g = 0; g < NUM_CTXT; g++) begin : g_resp
        ctxt_fifo #(
            .DATA_T (gather_resp_t),
            .DEPTH  (RESP_DEPTH)
        ) resp_fifo_i (
            .clk     (clk),
            .srst    (srst),
            .wr      (rd_done[g]),
            .wr_data (resp_in),
            .full    (resp_full[g]),
            .rd      (resp_ack[g]),
            .rd_vld  (resp_valid[g]),
            .rd_data (resp[g])
        );
    end : g_resp

endmodule : gather_core

`default_nettype wire

//--- source/gather_top.sv
`default_nettype none

module gather_top
    import gather_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                srst,
    input  wire logic                en,

    input  wire logic [NUM_CTXT-1:0] start_req,
    input  wire ptr_t                start_ptr [NUM_CTXT],
    output logic      [NUM_CTXT-1:0] start_rdy,

    output logic      [NUM_CTXT-1:0] resp_valid,
    output gather_resp_t             resp [NUM_CTXT],
    input  wire logic [NUM_CTXT-1:0] resp_ack,

    input  wire logic                desc_wr,
    input  wire ptr_t                desc_wr_addr,
    input  wire desc_t               desc_wr_data,

    output logic                     init_done
);

    // Read port between core and memory
    logic  rd_req;
    ptr_t  rd_addr;
    logic  rd_rdy;
    logic  rd_ack;
    desc_t rd_data;

    gather_core core_i (
        .clk        (clk),
        .srst       (srst),
        .en         (en),
        .start_req  (start_req),
        .start_ptr  (start_ptr),
        .start_rdy  (start_rdy),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ack   (resp_ack),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .rd_ack     (rd_ack),
        .rd_data    (rd_data),
        .init_done  (init_done)
    );

    desc_mem mem_i (
        .clk       (clk),
        .srst      (srst),
        .wr        (desc_wr),
        .wr_addr   (desc_wr_addr),
        .wr_data   (desc_wr_data),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .init_done (init_done)
    );

endmodule : gather_top

`default_nettype wire

//--- verif/gather_checker.sv
`default_nettype none

module gather_checker
    import gather_pkg::*;
(
    input wire logic                clk,
    input wire logic                srst,
    input wire logic                rd_req,
    input wire logic                rd_rdy,
    input wire logic                rd_ack,
    input wire logic                init_done,
    input wire logic [NUM_CTXT-1:0] grant
);

    timeunit 1ns;
    timeprecision 100ps;

    // -------------------------------------------------------------------------
    // Memory read port
    // -------------------------------------------------------------------------
    a_ack_after_accept: assert property (
        @(posedge clk) disable iff (srst) (rd_req && rd_rdy) |=> rd_ack
    ) else $error("rd_ack missing one cycle after an accepted read");

    a_no_stray_ack: assert property (
        @(posedge clk) disable iff (srst) !(rd_req && rd_rdy) |=> !rd_ack
    ) else $error("rd_ack without an accepted read one cycle before");

    a_no_early_req: assert property (
        @(posedge clk) disable iff (srst) !init_done |-> !rd_req
    ) else $error("rd_req raised before init_done");

    // Arbiter
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (srst) $onehot0(grant)
    ) else $error("arbiter grant is not one-hot");

endmodule : gather_checker

bind gather_core gather_checker checker_i (
    .clk       (clk),
    .srst      (srst),
    .rd_req    (rd_req),
    .rd_rdy    (rd_rdy),
    .rd_ack    (rd_ack),
    .init_done (init_done),
    .grant     (grant)
);

`default_nettype wire

//--- verif/gather_tb.sv
`default_nettype none

module gather_tb
    import gather_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        byte op;
        int  a0;
        int  a1;
        int  a2;
        int  a3;
        int  a4;
        int  a5;
    } case_t;

    logic                clk;
    logic                srst;
    logic                en;
    logic [NUM_CTXT-1:0] start_req;
    ptr_t                start_ptr [NUM_CTXT];
    logic [NUM_CTXT-1:0] start_rdy;
    logic [NUM_CTXT-1:0] resp_valid;
    gather_resp_t        resp [NUM_CTXT];
    logic [NUM_CTXT-1:0] resp_ack;
    logic                desc_wr;
    ptr_t                desc_wr_addr;
    desc_t               desc_wr_data;
    logic                init_done;

    case_t        case_q [$];
    gather_resp_t exp_q [NUM_CTXT][$];
    int           hold_cnt [NUM_CTXT];
    int           resp_idx [NUM_CTXT];
    int           exp_total = 0;
    int           resp_seen = 0;
    int           err_val = 0;
    int           err_other = 0;
    int           limit = 0;
    int           cycles = 0;
    logic         cases_loaded = 1'b0;
    logic [31:0]  rng_state = 32'd47925;

    gather_top dut_i (
        .clk          (clk),
        .srst         (srst),
        .en           (en),
        .start_req    (start_req),
        .start_ptr    (start_ptr),
        .start_rdy    (start_rdy),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .resp_ack     (resp_ack),
        .desc_wr      (desc_wr),
        .desc_wr_addr (desc_wr_addr),
        .desc_wr_data (desc_wr_data),
        .init_done    (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string format_resp(input gather_resp_t r);
        return $sformatf("ptr=%h eof=%b size=%h meta=%h err=%b",
                         r.ptr, r.eof, r.size, r.meta, r.err);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_resp(input string name, input gather_resp_t exp, input gather_resp_t act);
        if (act !== exp) begin
            $display("ERR %s expected %s actual %s", name, format_resp(exp), format_resp(act));
            err_val++;
        end
    endtask

    task automatic check_rdy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            err_val++;
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            err_val++;
        end
    endtask

    task automatic report_and_finish();
        $display("Summary: %0d value errors, %0d other errors, %0d of %0d responses checked",
                 err_val, err_other, resp_seen, exp_total);
        if (err_val + err_other == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // -------------------------------------------------------------------------
    // Case file
    // -------------------------------------------------------------------------
    task automatic read_cases();
        int           fd;
        int           n;
        int           extra;
        string        line;
        case_t        cs;
        gather_resp_t r;
        extra = 0;
        fd = $fopen("verif/gather_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/gather_cases.txt, no cases were run");
            err_other++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) inside {"W", "S", "H", "D", "E"}) begin
                    cs = '0;
                    cs.op = line.getc(0);
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                                cs.a0, cs.a1, cs.a2, cs.a3, cs.a4, cs.a5);
                    if (cs.op == "E") begin
                        r.ptr  = ptr_t'(cs.a1);
                        r.eof  = cs.a2[0];
                        r.size = cs.a3[SIZE_W-1:0];
                        r.meta = cs.a4[META_W-1:0];
                        r.err  = cs.a5[0];
                        exp_q[cs.a0].push_back(r);
                        exp_total++;
                    end else begin
                        if (cs.op == "H") extra += cs.a1;
                        if (cs.op == "D") extra += cs.a0;
                        case_q.push_back(cs);
                    end
                end
            end
            $fclose(fd);
        end
        limit = DESC_DEPTH + 12 * exp_total + extra + 200;
        cases_loaded = 1'b1;
    endtask

    // -------------------------------------------------------------------------
    // Commands
    // -------------------------------------------------------------------------
    task automatic load_desc(input case_t cs);
        desc_wr      = 1'b1;
        desc_wr_addr = ptr_t'(cs.a0);
        desc_wr_data = '{nxt_ptr: ptr_t'(cs.a1), eof: cs.a2[0], size: cs.a3[SIZE_W-1:0],
                         meta: cs.a4[META_W-1:0], err: cs.a5[0]};
        next_cycle();
        desc_wr = 1'b0;
    endtask

    task automatic start_chain(input int c, input int ptr);
        while (!start_rdy[c]) next_cycle();
        start_req[c] = 1'b1;
        start_ptr[c] = ptr_t'(ptr);
        next_cycle();
        start_req[c] = 1'b0;
        check_rdy($sformatf("ctxt%0d start_rdy after accept", c), 1'b0, start_rdy[c]);
    endtask

    task automatic hold_ack(input int c, input int n);
        @(negedge clk);
        hold_cnt[c] = n;
        next_cycle();
    endtask

    // Only a read granted before en fell may go out in the first cycle
    task automatic drop_en(input int n);
        en = 1'b0;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (i > 0 && dut_i.rd_req) begin
                $display("A memory read was issued while en was low");
                err_other++;
            end
        end
        next_cycle();
        en = 1'b1;
    endtask

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial begin
        int n;
        srst         = 1'b1;
        en           = 1'b1;
        start_req    = '0;
        desc_wr      = 1'b0;
        desc_wr_addr = '0;
        desc_wr_data = '0;
        for (int c = 0; c < NUM_CTXT; c++) begin
            start_ptr[c] = '0;
            hold_cnt[c]  = 0;
            resp_idx[c]  = 0;
        end
        read_cases();
        repeat (8) next_cycle();
        srst = 1'b0;

        // Outputs stay quiet during the clear sequence
        n = 0;
        while (1) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (init_done) break;
            for (int c = 0; c < NUM_CTXT; c++) begin
                check_rdy($sformatf("ctxt%0d start_rdy in init", c), 1'b1, start_rdy[c]);
                check_rdy($sformatf("ctxt%0d resp_valid in init", c), 1'b0, resp_valid[c]);
            end
        end
        check_cycles("init_done latency", DESC_DEPTH, n);
        next_cycle();

        foreach (case_q[i]) begin
            case (case_q[i].op)
                "W": load_desc(case_q[i]);
                "S": start_chain(case_q[i].a0, case_q[i].a1);
                "H": hold_ack(case_q[i].a0, case_q[i].a1);
                "D": drop_en(case_q[i].a0);
                default: next_cycle();
            endcase
        end

        while (resp_seen < exp_total) next_cycle();
        // Give stray responses a chance to show up
        repeat (20) next_cycle();
        for (int c = 0; c < NUM_CTXT; c++) begin
            check_rdy($sformatf("ctxt%0d start_rdy at end", c), 1'b1, start_rdy[c]);
        end
        report_and_finish();
    end

    // Random back-pressure unless an H hold is counting down
    initial begin
        resp_ack = '0;
        forever begin
            next_cycle();
            for (int c = 0; c < NUM_CTXT; c++) begin
                if (hold_cnt[c] > 0) begin
                    resp_ack[c] = 1'b0;
                    hold_cnt[c]--;
                end else begin
                    rng_state   = xorshift32(rng_state);
                    resp_ack[c] = (rng_state[1:0] != 2'b00);
                end
            end
        end
    end

    // Pops happen at the next edge, so compare at the falling edge
    initial begin
        gather_resp_t exp_r;
        forever begin
            @(negedge clk);
            for (int c = 0; c < NUM_CTXT; c++) begin
                if (resp_valid[c] && resp_ack[c]) begin
                    if (exp_q[c].size() == 0) begin
                        $display("Context %0d returned a response with none expected", c);
                        err_other++;
                    end else begin
                        exp_r = exp_q[c].pop_front();
                        check_resp($sformatf("ctxt%0d resp%0d", c, resp_idx[c]), exp_r, resp[c]);
                        resp_idx[c]++;
                        resp_seen++;
                    end
                end
            end
        end
    end

    initial begin
        wait (cases_loaded);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not complete", cycles);
        err_other++;
        report_and_finish();
    end

endmodule : gather_tb

`default_nettype wire

//--- verif/gather_cases.txt
# W addr nxt eof size meta err | S ctxt ptr | H ctxt cycles | D cycles
# E ctxt ptr eof size meta err (expected response, all fields hex)
W 01 00 1 040 11 0
W 10 11 0 100 21 0
W 11 12 0 200 22 0
W 12 00 1 0FF 23 0
W 20 25 0 7FF 31 0
W 25 21 0 001 32 1
W 21 2A 0 123 33 0
W 2A 00 1 456 34 1
W 30 31 0 080 41 0
W 31 00 1 081 42 0
W 02 03 0 010 51 0
W 03 00 1 020 52 1
W 38 39 0 300 61 0
W 39 3A 0 301 62 0
W 3A 3B 0 302 63 0
W 3B 3C 0 303 64 0
W 3C 3D 0 304 65 0
W 3D 00 1 305 66 0
# single chain, then all four contexts at once
S 0 01
H 3 1E
S 1 10
S 2 20
S 3 30
D 14
# restarts once each chain has read its eof descriptor
S 0 02
S 3 38
H 3 28
E 0 01 1 040 11 0
E 0 02 0 010 51 0
E 0 03 1 020 52 1
E 1 10 0 100 21 0
E 1 11 0 200 22 0
E 1 12 1 0FF 23 0
E 2 20 0 7FF 31 0
E 2 25 0 001 32 1
E 2 21 0 123 33 0
E 2 2A 1 456 34 1
E 3 30 0 080 41 0
E 3 31 1 081 42 0
E 3 38 0 300 61 0
E 3 39 0 301 62 0
E 3 3A 0 302 63 0
E 3 3B 0 303 64 0
E 3 3C 0 304 65 0
E 3 3D 1 305 66 0

//--- list.f
source/gather_pkg.sv
source/ctxt_fifo.sv
source/rr_arbiter.sv
source/desc_mem.sv
source/gather_core.sv
source/gather_top.sv
verif/gather_checker.sv
verif/gather_tb.sv

//--- Makefile
# Verilator flow for the gather engine

VERILATOR ?= verilator
TOP       ?= gather_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
JOBS      ?= 0
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

FAIL_MSG  := Finished with errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
